// ==== testbench/cache_cases.txt ====
# op addr wdata wstrb expected, all hex, op is R W CR or CW
# bit 12 of addr selects control space, expected is checked on reads only
R  0010 00000000 0 5a5a0010
R  0013 00000000 0 5a5a0013
R  0010 00000000 0 5a5a0010
W  0012 deadbeef 3 00000000
R  0012 00000000 0 5a5abeef
W  0025 cafef00d 6 00000000
R  0025 00000000 0 5afef025
R  0050 00000000 0 5a5a0050
R  0012 00000000 0 5a5abeef
W  0051 000000a5 1 00000000
R  0051 00000000 0 5a5a00a5
R  0011 00000000 0 5a5a0011
CR 1000 00000000 0 00000003
CR 1001 00000000 0 00000006
CR 1002 00000000 0 00000001
CR 1003 00000000 0 00000002
CW 1007 00000000 f 00000000
CR 1000 00000000 0 00000000
CR 1003 00000000 0 00000000
R  0026 00000000 0 5a5a0026
W  0030 01010101 f 00000000
W  0031 02020202 f 00000000
W  0032 03030303 f 00000000
W  0033 04040404 f 00000000
W  0027 05050505 f 00000000
CW 1006 00000000 f 00000000
R  0026 00000000 0 5a5a0026
R  0027 00000000 0 05050505
CR 1004 00000000 0 00000001
CR 1001 00000000 0 00000001
CR 1003 00000000 0 00000004
CR 1002 00000000 0 00000001
CR 1000 00000000 0 00000002
CR 1005 00000000 0 00000000

// ==== sim.f ====
hw/cache_pkg.sv
hw/cache_ctrl_pkg.sv
hw/cache_if.sv
hw/cache_front_end.sv
hw/cache_memory.sv
hw/cache_back_end.sv
hw/cache_control.sv
hw/cache_top.sv
testbench/cache_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Compile the cache testbench with Verilator, run it, and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module cache_tb -f sim.f -Mdir obj_dir \
   && ./obj_dir/Vcache_tb | tee /dev/stderr | grep "^Regression passed$" > /dev/null \
   && exit 0 \
   || exit 1

// ==== testbench/cache_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module cache_tb;
   import cache_pkg::*;
   import cache_ctrl_pkg::*;

   localparam int          TIMEOUT_CYCLES = 200;   // Per access
   localparam int          MEM_WORDS      = 4096;
   localparam logic [31:0] RNG_SEED       = 32'h07e47a9c;
   localparam logic [15:0] OP_R           = {8'h00, "R"};
   localparam logic [15:0] OP_W           = {8'h00, "W"};
   localparam logic [15:0] OP_CR          = "CR";   // Control read
   localparam logic [15:0] OP_CW          = "CW";   // Control write

   logic            clk;
   logic            arst_n;
   logic            req;
   logic [ADDR_W:0] addr;       // Bit 12 selects control space
   data_t           wdata;
   strb_t           wstrb;
   data_t           rdata;
   logic            ack;
   logic            mem_req;
   addr_t           mem_addr;
   data_t           mem_wdata;
   strb_t           mem_wstrb;
   data_t           mem_rdata;
   logic            mem_ack;
   logic            invalidate_in;
   logic            invalidate_out;
   logic            wtb_empty_in;
   logic            wtb_empty_out;

   int errors;
   int timeouts;
   int inval_pulses;     // Cycles with invalidate_out high
   int inval_expected;   // INVALIDATE writes issued

   data_t       mem [MEM_WORDS];   // Next-level memory
   logic [31:0] rng_state;
   int          mem_delay;         // Cycles left before mem_ack
   logic        mem_busy;          // Access seen, delay drawn

   cache_top uut (
      .clk, .arst_n, .req, .addr, .wdata, .wstrb, .rdata, .ack,
      .mem_req, .mem_addr, .mem_wdata, .mem_wstrb, .mem_rdata, .mem_ack,
      .invalidate_in, .invalidate_out, .wtb_empty_in, .wtb_empty_out
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   function automatic data_t merge_bytes(input data_t old_word, input data_t new_word,
                                         input strb_t strb);
      data_t result;
      result = old_word;
      for (int b = 0; b < NBYTES; b++) begin
         if (strb[b]) result[8*b +: 8] = new_word[8*b +: 8];   // Strobed bytes only
      end
      return result;
   endfunction

   // Memory model, acks 0 to 3 cycles after it sees mem_req
   always @(posedge clk or negedge arst_n) begin
      int wait_cycles;
      if (!arst_n) begin
         for (int a = 0; a < MEM_WORDS; a++) begin
            mem[a] <= data_t'(a) ^ 32'h5a5a0000;   // Each word tagged by its address
         end
         rng_state <= RNG_SEED;
         mem_ack   <= 1'b0;
         mem_rdata <= '0;
         mem_busy  <= 1'b0;
         mem_delay <= 0;
      end else if (mem_ack) begin
         mem_ack  <= 1'b0;                         // Transfer ends on this edge
         mem_busy <= 1'b0;
      end else if (mem_req) begin
         wait_cycles = mem_busy ? mem_delay : int'(rng_state[1:0]);
         if (!mem_busy) rng_state <= xorshift32(rng_state);
         mem_busy <= 1'b1;
         if (wait_cycles == 0) begin
            mem_ack <= 1'b1;
            if (mem_wstrb == '0) mem_rdata <= mem[mem_addr];
            else mem[mem_addr] <= merge_bytes(mem[mem_addr], mem_wdata, mem_wstrb);
         end else begin
            mem_delay <= wait_cycles - 1;
         end
      end
   end

   // Chain output, one cycle per invalidate command
   always @(negedge clk) begin
      if (arst_n && invalidate_out) inval_pulses++;
   end

   task automatic check_data(input string name, input data_t expected, input data_t actual);
      if (actual !== expected) begin
         $display("[ERROR] %s expected %h actual %h", name, expected, actual);
         errors++;
      end
   endtask

   task automatic check_count(input string name, input cnt_t expected, input cnt_t actual);
      if (actual !== expected) begin
         $display("[ERROR] %s expected %0d actual %0d", name, expected, actual);
         errors++;
      end
   endtask

   task automatic check_flag(input string name, input logic expected, input logic actual);
      if (actual !== expected) begin
         $display("[ERROR] %s expected %b actual %b", name, expected, actual);
         errors++;
      end
   endtask

   // One access, front end registers req so one cycle of it is enough
   task automatic run_access(input logic [ADDR_W:0] a, input data_t d, input strb_t s,
                             output bit ok, output data_t got);
      int cycles;
      @(posedge clk);
      req   <= 1'b1;
      addr  <= a;
      wdata <= d;
      wstrb <= s;                 // Payload held until the next access
      @(posedge clk);
      req <= 1'b0;
      ok     = 1'b0;
      got    = '0;
      cycles = 0;
      while (!ok && cycles < TIMEOUT_CYCLES) begin
         @(negedge clk);          // ack and rdata settled
         cycles++;
         if (ack) begin
            ok  = 1'b1;
            got = rdata;
         end
      end
      @(posedge clk);             // Ack cycle closes here
   endtask

   initial begin
      int               fd;
      int               n_fields;
      int               case_num;
      string            line;
      string            name;
      logic [15:0]      op;
      logic [ADDR_W:0]  c_addr;
      data_t            c_wdata;
      strb_t            c_wstrb;
      data_t            c_exp;
      bit               ok;
      data_t            got;
      ctrl_addr_e       reg_sel;

      req           <= 1'b0;
      addr          <= '0;
      wdata         <= '0;
      wstrb         <= '0;
      invalidate_in <= 1'b0;
      wtb_empty_in  <= 1'b1;      // No neighbour cache in the chain
      arst_n        <= 1'b0;
      case_num = 0;
      repeat (16) @(posedge clk);
      arst_n <= 1'b1;

      fd = $fopen("testbench/cache_cases.txt", "r");
      if (fd == 0) begin
         $display("Could not open testbench/cache_cases.txt");
         errors++;
      end else begin
         while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            n_fields = $sscanf(line, "%s %h %h %h %h", op, c_addr, c_wdata, c_wstrb, c_exp);
            if (n_fields != 5) continue;                 // Header or blank line
            case_num++;
            name = $sformatf("case %0d addr %h", case_num, c_addr);
            if (op != OP_R && op != OP_W && op != OP_CR && op != OP_CW) begin
               $display("Unknown operation in %s", name);
               errors++;
               continue;
            end
            run_access(c_addr, c_wdata, (op == OP_W || op == OP_CW) ? c_wstrb : '0, ok, got);
            if (!ok) begin
               $display("No ack within %0d cycles for %s, stopping", TIMEOUT_CYCLES, name);
               timeouts++;
               break;
            end
            reg_sel = ctrl_addr_e'(c_addr[CTRL_ADDR_W-1:0]);
            if (op == OP_R) begin
               check_data(name, c_exp, got);
            end else if (op == OP_CR) begin
               if (reg_sel inside {READ_HIT_CNT, READ_MISS_CNT, WRITE_HIT_CNT, WRITE_MISS_CNT})
                  check_count(name, cnt_t'(c_exp), cnt_t'(got));
               else
                  check_data(name, c_exp, got);                // Status bit
               if (reg_sel == WTBUF_EMPTY) begin
                  @(negedge clk);                              // Chain output settled
                  check_flag({name, " wtb_empty_out"}, c_exp[0] & wtb_empty_in,
                             wtb_empty_out);
               end
            end else if (op == OP_CW && reg_sel == INVALIDATE) begin
               inval_expected++;
               check_count({name, " invalidate_out"}, cnt_t'(inval_expected),
                           cnt_t'(inval_pulses));
            end
         end
         $fclose(fd);
      end

      if (case_num == 0 && fd != 0) begin
         $display("No cases were found in the case file");
         errors++;
      end
      check_count("invalidate_out pulses", cnt_t'(inval_expected), cnt_t'(inval_pulses));
      $display("Cases %0d, errors %0d, timeouts %0d", case_num, errors, timeouts);
      if (errors == 0 && timeouts == 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== hw/cache_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module cache_top (
   input  logic                       clk,
   input  logic                       arst_n,
   // Front end, IOb native slave
   input  logic                       req,
   input  logic [cache_pkg::ADDR_W:0] addr,
   input  cache_pkg::data_t           wdata,
   input  cache_pkg::strb_t           wstrb,
   output cache_pkg::data_t           rdata,
   output logic                       ack,
   // Back end, IOb native master
   output logic                       mem_req,
   output cache_pkg::addr_t           mem_addr,
   output cache_pkg::data_t           mem_wdata,
   output cache_pkg::strb_t           mem_wstrb,
   input  cache_pkg::data_t           mem_rdata,
   input  logic                       mem_ack,
   // Invalidate and buffer-empty chain
   input  logic                       invalidate_in,
   output logic                       invalidate_out,
   input  logic                       wtb_empty_in,
   output logic                       wtb_empty_out
);
   import cache_pkg::*;
   import cache_ctrl_pkg::*;

   cache_data_if data_if ();
   cache_be_if   be_if ();

   logic       ctrl_req, ctrl_wr, ctrl_ack, ctrl_invalidate;
   ctrl_addr_e ctrl_addr;
   data_t      ctrl_rdata;
   logic       read_hit, read_miss, write_hit, write_miss;

   assign invalidate_out = ctrl_invalidate | invalidate_in;   // Also clears this cache
   assign wtb_empty_out  = be_if.wtbuf_empty & wtb_empty_in;

   cache_front_end front_end (
      .clk, .arst_n, .req, .addr, .wdata, .wstrb, .rdata, .ack,
      .data (data_if),
      .ctrl_req, .ctrl_addr, .ctrl_wr, .ctrl_rdata, .ctrl_ack
   );

   cache_memory memory (
      .clk, .arst_n,
      .data       (data_if),
      .be         (be_if),
      .invalidate (invalidate_out),
      .read_hit, .read_miss, .write_hit, .write_miss
   );

   cache_back_end back_end (
      .clk, .arst_n,
      .be (be_if),
      .mem_req, .mem_addr, .mem_wdata, .mem_wstrb, .mem_rdata, .mem_ack
   );

   cache_control control (
      .clk, .arst_n,
      .req         (ctrl_req),
      .addr        (ctrl_addr),
      .wr          (ctrl_wr),
      .rdata       (ctrl_rdata),
      .ack         (ctrl_ack),
      .read_hit, .read_miss, .write_hit, .write_miss,
      .wtbuf_empty (be_if.wtbuf_empty),
      .wtbuf_full  (be_if.wtbuf_full),
      .invalidate  (ctrl_invalidate)
   );

endmodule

`default_nettype wire

// ==== hw/cache_control.sv ====
`timescale 1ns/100ps
`default_nettype none

module cache_control (
   input  logic                       clk,
   input  logic                       arst_n,
   input  logic                       req,
   input  cache_ctrl_pkg::ctrl_addr_e addr,
   input  logic                       wr,
   output cache_pkg::data_t           rdata,
   output logic                       ack,
   input  logic                       read_hit,
   input  logic                       read_miss,
   input  logic                       write_hit,
   input  logic                       write_miss,
   input  logic                       wtbuf_empty,
   input  logic                       wtbuf_full,
   output logic                       invalidate
);
   import cache_pkg::*;
   import cache_ctrl_pkg::*;

   cnt_t read_hit_cnt;
   cnt_t read_miss_cnt;
   cnt_t write_hit_cnt;
   cnt_t write_miss_cnt;
   logic start;

   assign start = req && !ack;    // Request stays up during its ack cycle

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         ack            <= 1'b0;
         invalidate     <= 1'b0;
         read_hit_cnt   <= '0;
         read_miss_cnt  <= '0;
         write_hit_cnt  <= '0;
         write_miss_cnt <= '0;
      end else begin
         ack        <= start;
         invalidate <= start && wr && (addr == INVALIDATE);   // Single cycle pulse
         if (start && wr && (addr == CNT_RESET)) begin
            read_hit_cnt   <= '0;
            read_miss_cnt  <= '0;
            write_hit_cnt  <= '0;
            write_miss_cnt <= '0;
         end else begin
            read_hit_cnt   <= read_hit_cnt + cnt_t'(read_hit);
            read_miss_cnt  <= read_miss_cnt + cnt_t'(read_miss);
            write_hit_cnt  <= write_hit_cnt + cnt_t'(write_hit);
            write_miss_cnt <= write_miss_cnt + cnt_t'(write_miss);
         end
      end
   end

   // Read data, don't care on writes
   always_ff @(posedge clk) begin
      if (start) begin
         case (addr)
            READ_HIT_CNT:   rdata <= read_hit_cnt;
            READ_MISS_CNT:  rdata <= read_miss_cnt;
            WRITE_HIT_CNT:  rdata <= write_hit_cnt;
            WRITE_MISS_CNT: rdata <= write_miss_cnt;
            WTBUF_EMPTY:    rdata <= {{(DATA_W-1){1'b0}}, wtbuf_empty};
            WTBUF_FULL:     rdata <= {{(DATA_W-1){1'b0}}, wtbuf_full};
            default:        rdata <= '0;
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== hw/cache_back_end.sv ====
`timescale 1ns/100ps
`default_nettype none

module cache_back_end (
   input  logic              clk,
   input  logic              arst_n,
   cache_be_if.slave         be,
   output logic              mem_req,
   output cache_pkg::addr_t  mem_addr,
   output cache_pkg::data_t  mem_wdata,
   output cache_pkg::strb_t  mem_wstrb,
   input  cache_pkg::data_t  mem_rdata,
   input  logic              mem_ack
);
   import cache_pkg::*;

   typedef struct packed {
      addr_t addr;
      data_t wdata;
      strb_t wstrb;
   } wtb_entry_t;

   wtb_entry_t               wtbuf [WTBUF_DEPTH];
   logic [WTBUF_DEPTH_W:0]   wr_ptr;       // Extra bit tells full from empty
   logic [WTBUF_DEPTH_W:0]   rd_ptr;
   logic [WTBUF_DEPTH_W:0]   wtb_count;
   logic                     push;
   logic                     mem_read;
   offset_t                  fill_cnt;     // Word within the line being filled

   assign wtb_count      = wr_ptr - rd_ptr;
   assign be.wtbuf_empty = (wtb_count == '0);       // Head stays until its mem_ack
   assign be.wtbuf_full  = (wtb_count == (WTBUF_DEPTH_W+1)'(WTBUF_DEPTH));

   assign push         = be.write_req && !be.wtbuf_full;
   assign be.write_ack = push;

   assign mem_read      = (mem_wstrb == '0);
   assign be.fill_valid = mem_req && mem_ack && mem_read;
   assign be.fill_rdata = mem_rdata;

   always_ff @(posedge clk) begin
      if (push) wtbuf[wr_ptr[WTBUF_DEPTH_W-1:0]] <= '{be.write_addr, be.write_wdata,
                                                     be.write_wstrb};
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         wr_ptr   <= '0;
         rd_ptr   <= '0;
         mem_req  <= 1'b0;
         fill_cnt <= '0;
      end else begin
         if (push) wr_ptr <= wr_ptr + 1'b1;

         if (mem_req) begin
            if (mem_ack) begin
               mem_req <= 1'b0;
               if (mem_read) fill_cnt <= fill_cnt + 1'b1;
               else          rd_ptr   <= rd_ptr + 1'b1;   // Pop the drained write
            end
         end else if (!be.wtbuf_empty || be.fill_req) begin
            mem_req <= 1'b1;
         end
      end
   end

   // Next access, buffered writes before any fill word
   always_ff @(posedge clk) begin
      if (!mem_req) begin
         if (!be.wtbuf_empty) begin
            mem_addr  <= wtbuf[rd_ptr[WTBUF_DEPTH_W-1:0]].addr;
            mem_wdata <= wtbuf[rd_ptr[WTBUF_DEPTH_W-1:0]].wdata;
            mem_wstrb <= wtbuf[rd_ptr[WTBUF_DEPTH_W-1:0]].wstrb;
         end else begin
            mem_addr  <= {be.fill_addr, fill_cnt};
            mem_wdata <= '0;
            mem_wstrb <= '0;                                 // Read
         end
      end
   end

   // A write refused on a full buffer stays offered, unchanged, until queued
   assert property (@(posedge clk) disable iff (!arst_n)
      be.write_req && !be.write_ack |=> be.write_req && $stable(be.write_addr)
                                        && $stable(be.write_wstrb))
      else $error("Write dropped or changed while the buffer was full");

   // Memory answers only an open request
   assert property (@(posedge clk) disable iff (!arst_n) mem_ack |-> mem_req)
      else $error("mem_ack without an open mem_req");

endmodule

`default_nettype wire

// ==== hw/cache_memory.sv ====
`timescale 1ns/100ps
`default_nettype none

module cache_memory (
   input  logic         clk,
   input  logic         arst_n,
   cache_data_if.slave  data,
   cache_be_if.master   be,
   input  logic         invalidate,
   output logic         read_hit,
   output logic         read_miss,
   output logic         write_hit,
   output logic         write_miss
);
   import cache_pkg::*;

   logic [NLINES-1:0] valid_q;
   tag_t              tag_mem  [NLINES];
   data_t             data_mem [NLINES][NWORDS];

   mem_state_e state;
   offset_t    fill_cnt;     // Next word expected from the back end

   tag_t    tag;
   index_t  index;
   offset_t offset;
   logic    wr;
   logic    hit;
   logic    in_lookup;
   logic    fill_last;

   // Address split
   assign tag    = data.addr[ADDR_W-1 -: TAG_W];
   assign index  = data.addr[WORD_OFFSET_W +: NLINES_W];
   assign offset = data.addr[WORD_OFFSET_W-1:0];

   assign wr        = |data.wstrb;
   assign hit       = valid_q[index] && (tag_mem[index] == tag);
   assign in_lookup = (state == LOOKUP);
   assign fill_last = be.fill_valid && (fill_cnt == offset_t'(NWORDS - 1));

   // Write-through, every write goes to the buffer
   assign be.write_req   = in_lookup && wr;      // Held while the buffer is full
   assign be.write_addr  = data.addr;
   assign be.write_wdata = data.wdata;
   assign be.write_wstrb = data.wstrb;

   assign be.fill_req  = (state == FILL);
   assign be.fill_addr = data.addr[ADDR_W-1:WORD_OFFSET_W];

   // Event pulses, one per access
   assign read_hit   = in_lookup && !wr && hit;
   assign read_miss  = in_lookup && !wr && !hit;
   assign write_hit  = be.write_req && be.write_ack && hit;
   assign write_miss = be.write_req && be.write_ack && !hit;

   assign data.ack   = read_hit || write_hit || write_miss || (state == FILL_DONE);
   assign data.rdata = data_mem[index][offset];

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state    <= IDLE;
         fill_cnt <= '0;
         valid_q  <= '0;
      end else begin
         case (state)
            IDLE:      if (data.req) state <= LOOKUP;
            LOOKUP: begin
               if (read_miss)     state <= FILL;
               else if (data.ack) state <= IDLE;     // Writes wait here on a full buffer
            end
            FILL:      if (fill_last) state <= FILL_DONE;
            FILL_DONE: state <= IDLE;
            default:   state <= IDLE;
         endcase

         if (be.fill_valid) fill_cnt <= fill_cnt + 1'b1;   // Wraps to 0 after the line

         if (fill_last) valid_q[index] <= 1'b1;
         if (invalidate) valid_q <= '0;                     // Wins over a fill
      end
   end

   // Arrays, tags and words
   always_ff @(posedge clk) begin
      if (fill_last) tag_mem[index] <= tag;

      if (be.fill_valid) begin
         data_mem[index][fill_cnt] <= be.fill_rdata;
      end else if (write_hit) begin
         for (int b = 0; b < NBYTES; b++) begin
            if (data.wstrb[b]) data_mem[index][offset][8*b +: 8] <= data.wdata[8*b +: 8];
         end
      end
   end

   // Back end may only return words for a pending refill
   assert property (@(posedge clk) disable iff (!arst_n) be.fill_valid |-> state == FILL)
      else $error("Fill word outside of FILL state");

endmodule

`default_nettype wire

// ==== hw/cache_front_end.sv ====
`timescale 1ns/100ps
`default_nettype none

module cache_front_end (
   input  logic                      clk,
   input  logic                      arst_n,
   input  logic                      req,
   input  logic [cache_pkg::ADDR_W:0] addr,   // MSB selects control space
   input  cache_pkg::data_t          wdata,
   input  cache_pkg::strb_t          wstrb,
   output cache_pkg::data_t          rdata,
   output logic                      ack,
   cache_data_if.master              data,
   output logic                      ctrl_req,
   output cache_ctrl_pkg::ctrl_addr_e ctrl_addr,
   output logic                      ctrl_wr,
   input  cache_pkg::data_t          ctrl_rdata,
   input  logic                      ctrl_ack
);
   import cache_pkg::*;
   import cache_ctrl_pkg::*;

   logic            req_r;
   logic [ADDR_W:0] addr_r;
   data_t           wdata_r;
   strb_t           wstrb_r;
   logic            accept;
   logic            ctrl_sel;

   assign accept   = !req_r || ack;    // Idle, or current request ends this cycle
   assign ctrl_sel = addr_r[ADDR_W];

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         req_r <= 1'b0;
      end else if (accept) begin
         req_r <= req;
      end
   end

   // Payload only changes when a new request is taken
   always_ff @(posedge clk) begin
      if (accept && req) begin
         addr_r  <= addr;
         wdata_r <= wdata;
         wstrb_r <= wstrb;
      end
   end

   assign data.req   = req_r && !ctrl_sel;
   assign data.addr  = addr_r[ADDR_W-1:0];
   assign data.wdata = wdata_r;
   assign data.wstrb = wstrb_r;

   assign ctrl_req  = req_r && ctrl_sel;
   assign ctrl_addr = ctrl_addr_e'(addr_r[CTRL_ADDR_W-1:0]);
   assign ctrl_wr   = |wstrb_r;

   assign ack   = data.ack | ctrl_ack;              // Only the selected side answers
   assign rdata = ctrl_sel ? ctrl_rdata : data.rdata;

   // Only one side can hold the request
   assert property (@(posedge clk) disable iff (!arst_n) !(data.ack && ctrl_ack))
      else $error("Cache memory and control acknowledged together");

endmodule

`default_nettype wire

// ==== hw/cache_if.sv ====
`timescale 1ns/100ps
`default_nettype none

// Registered front-end request into the cache memory
interface cache_data_if;
   import cache_pkg::*;

   logic  req;
   addr_t addr;
   data_t wdata;
   strb_t wstrb;    // All zero means read
   data_t rdata;
   logic  ack;

   modport master (output req, addr, wdata, wstrb, input rdata, ack);
   modport slave  (input req, addr, wdata, wstrb, output rdata, ack);
endinterface

// Cache memory to back end: write-through channel and line fill channel
interface cache_be_if;
   import cache_pkg::*;

   logic       write_req;
   addr_t      write_addr;
   data_t      write_wdata;
   strb_t      write_wstrb;
   logic       write_ack;      // Entry queued
   logic       fill_req;
   line_addr_t fill_addr;
   logic       fill_valid;     // One word per pulse, offset order
   data_t      fill_rdata;
   logic       wtbuf_empty;
   logic       wtbuf_full;

   modport master (output write_req, write_addr, write_wdata, write_wstrb,
                   output fill_req, fill_addr,
                   input  write_ack, fill_valid, fill_rdata, wtbuf_empty, wtbuf_full);
   modport slave  (input  write_req, write_addr, write_wdata, write_wstrb,
                   input  fill_req, fill_addr,
                   output write_ack, fill_valid, fill_rdata, wtbuf_empty, wtbuf_full);
endinterface

`default_nettype wire

// ==== hw/cache_ctrl_pkg.sv ====
`default_nettype none

package cache_ctrl_pkg;

   localparam int CTRL_ADDR_W = 4;   // Low address bits in control space
   localparam int CNT_W       = 32;

   // Control register map
   typedef enum logic [CTRL_ADDR_W-1:0] {
      READ_HIT_CNT   = 4'h0,   // Counters, read only
      READ_MISS_CNT  = 4'h1,
      WRITE_HIT_CNT  = 4'h2,
      WRITE_MISS_CNT = 4'h3,
      WTBUF_EMPTY    = 4'h4,   // Status, bit 0
      WTBUF_FULL     = 4'h5,
      INVALIDATE     = 4'h6,   // Commands, any write
      CNT_RESET      = 4'h7
   } ctrl_addr_e;

   typedef logic [CNT_W-1:0] cnt_t;

endpackage

`default_nettype wire

// ==== hw/cache_pkg.sv ====
`default_nettype none

package cache_pkg;

   // Geometry, word addressed
   localparam int ADDR_W        = 12;
   localparam int DATA_W        = 32;
   localparam int NBYTES        = DATA_W / 8;
   localparam int NLINES_W      = 4;                      // 16 lines
   localparam int WORD_OFFSET_W = 2;                      // 4 words per line
   localparam int TAG_W         = ADDR_W - NLINES_W - WORD_OFFSET_W;
   localparam int WTBUF_DEPTH_W = 2;

   localparam int NLINES      = 2 ** NLINES_W;
   localparam int NWORDS      = 2 ** WORD_OFFSET_W;
   localparam int WTBUF_DEPTH = 2 ** WTBUF_DEPTH_W;

   // Address fields, MSB to LSB: tag, index, offset
   typedef logic [ADDR_W-1:0]        addr_t;
   typedef logic [DATA_W-1:0]        data_t;
   typedef logic [NBYTES-1:0]        strb_t;
   typedef logic [TAG_W-1:0]         tag_t;
   typedef logic [NLINES_W-1:0]      index_t;
   typedef logic [WORD_OFFSET_W-1:0] offset_t;
   typedef logic [ADDR_W-WORD_OFFSET_W-1:0] line_addr_t;   // Tag and index

   // Cache memory FSM
   typedef enum logic [1:0] {
      IDLE      = 2'd0,   // Waiting for a registered request
      LOOKUP    = 2'd1,   // Tag compare, answers hits and queues writes
      FILL      = 2'd2,   // Line refill from the back end
      FILL_DONE = 2'd3    // Answers the read from the new line
   } mem_state_e;

endpackage

`default_nettype wire
